/* list.f */
hdl/fp2_pkg.sv
hdl/fe_add_mod.sv
hdl/fe_sub_mod.sv
hdl/fe2_mnr_stream.sv
hdl/fe2_mnr_top.sv
bench/fe2_mnr_chk.sv
bench/fe2_mnr_tb.sv

/* run.sh */
#!/bin/sh
# verilator build and run of fe2_mnr_tb, result taken from sim.log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module fe2_mnr_tb \
  -Mdir obj_dir -f list.f > build.log 2>&1 || { cat build.log; echo "FAIL: build"; exit 1; }

./obj_dir/Vfe2_mnr_tb > sim.log 2>&1 || echo "simulation exited with an error status"
cat sim.log

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL: no result line"; exit 1; }

/* bench/fe2_mnr_tb.sv */
// clock, reset, lfsr, stimulus table, sender, receiver and checks for fe2_mnr_top.
module fe2_mnr_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fp2_pkg::*;

  localparam int          N_ROWS   = 24;
  localparam int          N_DIR    = 8;
  localparam int          WAIT_MAX = 400;
  localparam logic [31:0] SEED     = 32'h6f11_575f;
  localparam fe_t         P_M1     = FE_P - fe_t'(1);

  // directed operands.
  // zeros, a0 = a1, a1 = 0, sums at and past p, a0 < a1.
  localparam fe_t DIR_A0 [N_DIR] = '{
    fe_t'(0), fe_t'(5), fe_t'(123), P_M1, P_M1, fe_t'(0), fe_t'(1), P_M1
  };
  localparam fe_t DIR_A1 [N_DIR] = '{
    fe_t'(0), fe_t'(5), fe_t'(0), P_M1, fe_t'(1), fe_t'(1), P_M1, fe_t'(0)
  };

  // one table row holds operands, tag and expected result.
  typedef struct packed {
    fe_t  a0;
    fe_t  a1;
    tag_t tag;
    fe_t  c0;
    fe_t  c1;
  } row_t;

  logic        i_clk;
  logic        i_rst;
  fe_beat_t    fe2;
  logic        fe2_val;
  logic        fe2_rdy;
  fe_beat_t    mnr;
  logic        mnr_val;
  logic        mnr_rdy;
  row_t        tbl [N_ROWS];
  logic [31:0] lfsr;
  int          n_val_err;
  int          n_fail;
  int          n_pairs;

  fe2_mnr_top dut0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_fe2     (fe2),
    .i_fe2_val (fe2_val),
    .o_fe2_rdy (fe2_rdy),
    .o_mnr     (mnr),
    .o_mnr_val (mnr_val),
    .i_mnr_rdy (mnr_rdy)
  );

  // 100 ns clock.
  initial begin
    i_clk = 1'b0;
    forever begin
      #50 i_clk = ~i_clk;
    end
  end

  ////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////

  // galois lfsr stepped once per bit.
  function automatic logic rand_bit();
    lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    return lfsr[0];
  endfunction

  function automatic fe_t rand_fe();
    fe_t v;
    v = '0;
    for (int b = 0; b < FE_W; b++) begin
      v[b] = rand_bit();
    end
    // p is above 2^380 so one subtract is enough.
    if (v >= FE_P) begin
      v = v - FE_P;
    end
    return v;
  endfunction

  // a0 + p - a1 in one extra bit and then reduced.
  function automatic fe_t diff_mod_p(input fe_t a0, input fe_t a1);
    logic [FE_W:0] t;
    t = {1'b0, a0} + {1'b0, FE_P} - {1'b0, a1};
    if (t >= {1'b0, FE_P}) begin
      t = t - {1'b0, FE_P};
    end
    return t[FE_W-1:0];
  endfunction

  // subtract p from the sum in one extra bit.
  // a borrow means the sum was already below p.
  function automatic fe_t sum_mod_p(input fe_t a0, input fe_t a1);
    logic [FE_W:0] t;
    t = {1'b0, a0} + {1'b0, a1} - {1'b0, FE_P};
    if (t[FE_W]) begin
      return a0 + a1;
    end
    return t[FE_W-1:0];
  endfunction

  task automatic fill_table();
    fe_t a0;
    fe_t a1;
    for (int r = 0; r < N_ROWS; r++) begin
      if (r < N_DIR) begin
        a0 = DIR_A0[r];
        a1 = DIR_A1[r];
      end else begin
        a0 = rand_fe();
        a1 = rand_fe();
      end
      tbl[r].a0  = a0;
      tbl[r].a1  = a1;
      tbl[r].tag = tag_t'(r * 11 + 3);
      tbl[r].c0  = diff_mod_p(a0, a1);
      tbl[r].c1  = sum_mod_p(a0, a1);
    end
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_fe(input fe_t got, input fe_t exp, input string name);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
      n_val_err++;
    end
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp, input string name);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
      n_val_err++;
    end
  endtask

  task automatic check_frame(input fe_beat_t got, input logic sop, input logic eop,
                             input string name);
    if ({got.sop, got.eop} !== {sop, eop}) begin
      $display("** Error at %0d ns: %s sop/eop got %b%b expected %b%b",
               $time, name, got.sop, got.eop, sop, eop);
      n_val_err++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
      n_val_err++;
    end
  endtask

  ////////////////////////////////////////
  // sender and receiver
  ////////////////////////////////////////

  // data and valid held until the beat is taken.
  task automatic send_beat(input fe_beat_t b);
    int   n;
    logic done;
    @(negedge i_clk);
    fe2     = b;
    fe2_val = 1'b1;
    done    = 1'b0;
    n       = 0;
    while (!done && n < WAIT_MAX) begin
      @(posedge i_clk);
      done = fe2_rdy;
      n++;
    end
    if (!done) begin
      $display("timeout: input beat not accepted at %0d ns", $time);
      n_fail++;
    end
  endtask

  task automatic run_sender();
    int gap;
    for (int r = 0; r < N_ROWS; r++) begin
      send_beat(fe_beat_t'{dat: tbl[r].a0, sop: 1'b1, eop: 1'b0, ctl: tbl[r].tag});
      send_beat(fe_beat_t'{dat: tbl[r].a1, sop: 1'b0, eop: 1'b1, ctl: tbl[r].tag});
      // half the elements go back to back.
      gap = 0;
      while (gap < 3 && rand_bit()) begin
        gap++;
      end
      repeat (gap) begin
        @(negedge i_clk);
        fe2_val = 1'b0;
      end
    end
    @(negedge i_clk);
    fe2_val = 1'b0;
  endtask

  // beat captured on the falling edge and taken on the next rising edge.
  task automatic recv_beat(output fe_beat_t b, output logic got);
    int n;
    b   = '0;
    got = 1'b0;
    n   = 0;
    while (!got && n < WAIT_MAX) begin
      @(negedge i_clk);
      // ready about three cycles in four.
      mnr_rdy = rand_bit() | rand_bit();
      if (mnr_val && mnr_rdy) begin
        b   = mnr;
        got = 1'b1;
      end
      n++;
    end
  endtask

  task automatic run_receiver();
    fe_beat_t b;
    logic     got;
    logic     stuck;
    stuck = 1'b0;
    for (int r = 0; r < N_ROWS && !stuck; r++) begin
      recv_beat(b, got);
      if (got) begin
        check_frame(b, 1'b1, 1'b0, $sformatf("row %0d c0 beat", r));
        check_fe(b.dat, tbl[r].c0, $sformatf("row %0d o_mnr.dat c0", r));
        check_tag(b.ctl, tbl[r].tag, $sformatf("row %0d o_mnr.ctl c0", r));
        recv_beat(b, got);
      end
      if (got) begin
        check_frame(b, 1'b0, 1'b1, $sformatf("row %0d c1 beat", r));
        check_fe(b.dat, tbl[r].c1, $sformatf("row %0d o_mnr.dat c1", r));
        check_tag(b.ctl, tbl[r].tag, $sformatf("row %0d o_mnr.ctl c1", r));
        n_pairs++;
      end else begin
        $display("timeout: no output beat for row %0d at %0d ns", r, $time);
        n_fail++;
        stuck = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    lfsr      = SEED;
    n_val_err = 0;
    n_fail    = 0;
    n_pairs   = 0;
    i_rst     = 1'b1;
    fe2       = '0;
    fe2_val   = 1'b0;
    mnr_rdy   = 1'b0;
    fill_table();
    repeat (10) begin
      @(posedge i_clk);
    end
    @(negedge i_clk);
    i_rst = 1'b0;
    // idle and empty before the first beat.
    repeat (4) begin
      @(negedge i_clk);
      check_flag(mnr_val, 1'b0, "o_mnr_val");
      check_flag(fe2_rdy, 1'b1, "o_fe2_rdy");
    end
    fork
      run_sender();
      run_receiver();
    join
    // no beat may follow the last pair.
    repeat (20) begin
      @(negedge i_clk);
      mnr_rdy = 1'b1;
      if (mnr_val) begin
        $display("unexpected output beat after the last row at %0d ns", $time);
        n_fail++;
      end
    end
    if (n_pairs != N_ROWS) begin
      $display("received %0d pairs instead of %0d", n_pairs, N_ROWS);
      n_fail++;
    end
    $display("%0d pairs received, %0d value errors, %0d other errors",
             n_pairs, n_val_err, n_fail);
    if (n_val_err == 0 && n_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* bench/fe2_mnr_chk.sv */
// reset, stall, framing and pair-hold assertions bound into fe2_mnr_stream.
module fe2_mnr_chk (
  input logic               i_clk,
  input logic               i_rst,
  input logic               i_in_val,
  input logic               i_in_rdy,
  input fp2_pkg::fe2_pair_t i_pair,
  input logic               i_add_val,
  input logic               i_add_rdy,
  input logic               i_sub_val,
  input logic               i_sub_rdy,
  input fp2_pkg::fe_beat_t  i_mnr,
  input logic               i_mnr_val,
  input logic               i_mnr_rdy
);
  timeunit 1ns;
  timeprecision 1ps;

  // some input beat taken since reset.
  logic seen_in;
  // eop is due after a sop beat has left.
  logic want_eop;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_in  <= 1'b0;
      want_eop <= 1'b0;
    end else begin
      if (i_in_val && i_in_rdy) begin
        seen_in <= 1'b1;
      end
      if (i_mnr_val && i_mnr_rdy) begin
        want_eop <= i_mnr.sop;
      end
    end
  end

  // quiet in reset.
  a_rst_quiet: assert property (@(posedge i_clk) i_rst |=> !i_mnr_val)
    else $error("o_mnr_val high after a reset cycle");

  // quiet until the first input.
  a_idle_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
    !seen_in |-> !i_mnr_val)
    else $error("o_mnr_val high before any input beat");

  // stalled beat holds.
  a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mnr_val && !i_mnr_rdy |=> i_mnr_val && $stable(i_mnr))
    else $error("o_mnr changed while stalled");

  // sop and eop beats alternate.
  a_frame: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mnr_val |-> (want_eop ? (i_mnr.eop && !i_mnr.sop) : (i_mnr.sop && !i_mnr.eop)))
    else $error("o_mnr framing out of order");

  // operand pair stays put while either unit has yet to take it.
  a_pair_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_add_val && !i_add_rdy) || (i_sub_val && !i_sub_rdy) |=> $stable(i_pair))
    else $error("operand pair changed before both units had taken it");

endmodule

bind fe2_mnr_stream fe2_mnr_chk chk0 (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_in_val  (i_fe2_val),
  .i_in_rdy  (o_fe2_rdy),
  .i_pair    (o_pair),
  .i_add_val (o_add_val),
  .i_add_rdy (i_add_rdy),
  .i_sub_val (o_sub_val),
  .i_sub_rdy (i_sub_rdy),
  .i_mnr     (o_mnr),
  .i_mnr_val (o_mnr_val),
  .i_mnr_rdy (i_mnr_rdy)
);

/* hdl/fe2_mnr_top.sv */
// top level for fp2 multiply by (1 + u): stream stage, adder and subtractor.
module fe2_mnr_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  fp2_pkg::fe_beat_t i_fe2,
  input  logic              i_fe2_val,
  output logic              o_fe2_rdy,
  output fp2_pkg::fe_beat_t o_mnr,
  output logic              o_mnr_val,
  input  logic              i_mnr_rdy
);
  import fp2_pkg::*;

  // operand pair, one bus into both units.
  fe2_pair_t pair_in;
  logic      add_in_val;
  logic      add_in_rdy;
  logic      sub_in_val;
  logic      sub_in_rdy;
  // results, c0 and ctl only.
  fe2_pair_t add_out;
  logic      add_out_val;
  logic      add_out_rdy;
  fe2_pair_t sub_out;
  logic      sub_out_val;
  logic      sub_out_rdy;

  fe2_mnr_stream stream0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_fe2     (i_fe2),
    .i_fe2_val (i_fe2_val),
    .o_fe2_rdy (o_fe2_rdy),
    .o_pair    (pair_in),
    .o_add_val (add_in_val),
    .o_sub_val (sub_in_val),
    .i_add_rdy (add_in_rdy),
    .i_sub_rdy (sub_in_rdy),
    .i_add     (add_out),
    .i_add_val (add_out_val),
    .i_sub     (sub_out),
    .i_sub_val (sub_out_val),
    .o_add_rdy (add_out_rdy),
    .o_sub_rdy (sub_out_rdy),
    .o_mnr     (o_mnr),
    .o_mnr_val (o_mnr_val),
    .i_mnr_rdy (i_mnr_rdy)
  );

  // c1 = a0 + a1.
  fe_add_mod add0 (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_pair (pair_in),
    .i_val  (add_in_val),
    .o_rdy  (add_in_rdy),
    .o_sum  (add_out),
    .o_val  (add_out_val),
    .i_rdy  (add_out_rdy)
  );

  // c0 = a0 - a1.
  fe_sub_mod sub0 (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_pair (pair_in),
    .i_val  (sub_in_val),
    .o_rdy  (sub_in_rdy),
    .o_diff (sub_out),
    .o_val  (sub_out_val),
    .i_rdy  (sub_out_rdy)
  );

endmodule

/* hdl/fe2_mnr_stream.sv */
// fp2 stream unpack into an operand pair and repack of sub/add results as a stream.
module fe2_mnr_stream (
  input  logic               i_clk,
  input  logic               i_rst,
  // input stream, c0 with sop then c1 with eop.
  input  fp2_pkg::fe_beat_t  i_fe2,
  input  logic               i_fe2_val,
  output logic               o_fe2_rdy,
  // operand pair, shared by adder and subtractor.
  output fp2_pkg::fe2_pair_t o_pair,
  output logic               o_add_val,
  output logic               o_sub_val,
  input  logic               i_add_rdy,
  input  logic               i_sub_rdy,
  // results back from adder and subtractor.
  input  fp2_pkg::fe2_pair_t i_add,
  input  logic               i_add_val,
  input  fp2_pkg::fe2_pair_t i_sub,
  input  logic               i_sub_val,
  output logic               o_add_rdy,
  output logic               o_sub_rdy,
  // output stream, difference then sum.
  output fp2_pkg::fe_beat_t  o_mnr,
  output logic               o_mnr_val,
  input  logic               i_mnr_rdy
);
  import fp2_pkg::*;

  // input beat accepted this cycle.
  logic in_xfer;
  // output register empty or leaving.
  logic out_ok;
  // 0 waits for the subtractor, 1 for the adder.
  logic phase;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  always_comb begin
    // both pair outputs free before a new beat.
    o_fe2_rdy = (!o_add_val || i_add_rdy) && (!o_sub_val || i_sub_rdy);
    // only the result matching the phase is taken.
    o_sub_rdy = !phase && out_ok;
    o_add_rdy = phase && out_ok;
  end

  assign in_xfer = i_fe2_val && o_fe2_rdy;
  assign out_ok  = !o_mnr_val || i_mnr_rdy;

  ////////////////////////////////////////
  // unpack side
  ////////////////////////////////////////

  // each valid drops on its own transfer.
  // the two pipes drain at different times under back-pressure.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_add_val <= 1'b0;
      o_sub_val <= 1'b0;
    end else begin
      if (o_add_val && i_add_rdy) begin
        o_add_val <= 1'b0;
      end
      if (o_sub_val && i_sub_rdy) begin
        o_sub_val <= 1'b0;
      end
      // pair complete on the eop beat.
      if (in_xfer && i_fe2.eop) begin
        o_add_val <= 1'b1;
        o_sub_val <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (in_xfer) begin
      if (i_fe2.sop) begin
        o_pair.c0 <= i_fe2.dat;
      end
      if (i_fe2.eop) begin
        o_pair.c1  <= i_fe2.dat;
        o_pair.ctl <= i_fe2.ctl;
      end
    end
  end

  ////////////////////////////////////////
  // repack side
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mnr_val <= 1'b0;
      phase     <= 1'b0;
    end else if (out_ok) begin
      if (!phase) begin
        o_mnr_val <= i_sub_val;
        if (i_sub_val) begin
          phase <= 1'b1;
        end
      end else begin
        o_mnr_val <= i_add_val;
        if (i_add_val) begin
          phase <= 1'b0;
        end
      end
    end
  end

  // stalled beat keeps its payload.
  always_ff @(posedge i_clk) begin
    if (out_ok) begin
      if (!phase) begin
        o_mnr <= '{dat: i_sub.c0, sop: 1'b1, eop: 1'b0, ctl: i_sub.ctl};
      end else begin
        o_mnr <= '{dat: i_add.c0, sop: 1'b0, eop: 1'b1, ctl: i_add.ctl};
      end
    end
  end

endmodule

/* hdl/fe_sub_mod.sv */
// two-stage pipelined modular subtractor over fp with a stalling valid/ready pipe.
module fe_sub_mod (
  input  logic               i_clk,
  input  logic               i_rst,
  // operand pair, a0 in c0 and a1 in c1.
  input  fp2_pkg::fe2_pair_t i_pair,
  input  logic               i_val,
  output logic               o_rdy,
  // (a0 - a1) mod p in c0.
  output fp2_pkg::fe2_pair_t o_diff,
  output logic               o_val,
  input  logic               i_rdy
);
  import fp2_pkg::*;

  // one enable for the whole pipe.
  logic          pipe_en;
  // stage one, difference with the borrow on top.
  logic [FE_W:0] s1_diff;
  tag_t          s1_ctl;
  logic          s1_val;
  // stage two, corrected result.
  fe_t           s2_res;
  tag_t          s2_ctl;
  logic          s2_val;

  ////////////////////////////////////////
  // pipe control
  ////////////////////////////////////////

  // same stall rule as the adder.
  assign pipe_en = !s2_val || i_rdy;
  assign o_rdy   = pipe_en;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else if (pipe_en) begin
      s1_val <= i_val;
      s2_val <= s1_val;
    end
  end

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (pipe_en) begin
      // stage one.
      // bit FE_W set means a0 < a1.
      s1_diff <= {1'b0, i_pair.c0} - {1'b0, i_pair.c1};
      s1_ctl  <= i_pair.ctl;
      // stage two.
      // wrapped difference plus p lands back in [0, p).
      if (s1_diff[FE_W]) begin
        s2_res <= s1_diff[FE_W-1:0] + FE_P;
      end else begin
        s2_res <= s1_diff[FE_W-1:0];
      end
      s2_ctl <= s1_ctl;
    end
  end

  // result goes out in c0, c1 held at zero.
  assign o_diff = '{c0: s2_res, c1: fe_t'(0), ctl: s2_ctl};
  assign o_val  = s2_val;

endmodule

/* hdl/fe_add_mod.sv */
// two-stage pipelined modular adder over fp with a stalling valid/ready pipe.
module fe_add_mod (
  input  logic               i_clk,
  input  logic               i_rst,
  // operand pair, a0 in c0 and a1 in c1.
  input  fp2_pkg::fe2_pair_t i_pair,
  input  logic               i_val,
  output logic               o_rdy,
  // (a0 + a1) mod p in c0.
  output fp2_pkg::fe2_pair_t o_sum,
  output logic               o_val,
  input  logic               i_rdy
);
  import fp2_pkg::*;

  // one enable for the whole pipe.
  logic          pipe_en;
  // stage one, raw sum one bit wider than an element.
  logic [FE_W:0] s1_sum;
  tag_t          s1_ctl;
  logic          s1_val;
  // stage one sum at or above p.
  logic          s1_ge_p;
  // stage two, reduced result.
  fe_t           s2_res;
  tag_t          s2_ctl;
  logic          s2_val;

  ////////////////////////////////////////
  // pipe control
  ////////////////////////////////////////

  // advance when the last stage is empty or leaving.
  assign pipe_en = !s2_val || i_rdy;
  assign o_rdy   = pipe_en;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else if (pipe_en) begin
      s1_val <= i_val;
      s2_val <= s1_val;
    end
  end

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  // sum is below 2p, so one conditional subtract reduces it.
  assign s1_ge_p = s1_sum >= {1'b0, FE_P};

  always_ff @(posedge i_clk) begin
    if (pipe_en) begin
      // stage one.
      s1_sum <= {1'b0, i_pair.c0} + {1'b0, i_pair.c1};
      s1_ctl <= i_pair.ctl;
      // stage two.
      // top bit drops out after the subtract.
      if (s1_ge_p) begin
        s2_res <= s1_sum[FE_W-1:0] - FE_P;
      end else begin
        s2_res <= s1_sum[FE_W-1:0];
      end
      s2_ctl <= s1_ctl;
    end
  end

  // result goes out in c0, c1 held at zero.
  assign o_sum = '{c0: s2_res, c1: fe_t'(0), ctl: s2_ctl};
  assign o_val = s2_val;

endmodule

/* hdl/fp2_pkg.sv */
// field width, bls12-381 prime, tag type, element, stream beat and pair structs.
package fp2_pkg;

  ////////////////////////////////////////
  // field constants
  ////////////////////////////////////////

  // width of one base field element.
  localparam int FE_W = 381;

  // width of the control tag on every stream.
  localparam int TAG_W = 8;

  // bls12-381 base prime with its top bit set.
  localparam logic [FE_W-1:0] FE_P = {
    93'h1a0111ea397fe69a4b1ba7b6,
    96'h434bacd764774b84f38512bf,
    96'h6730d2a0f6b0f6241eabfffe,
    96'hb153ffffb9feffffffffaaab
  };

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // one element of fp.
  typedef logic [FE_W-1:0] fe_t;

  // control tag.
  // carried untouched from input beat to output beats.
  typedef logic [TAG_W-1:0] tag_t;

  // one beat of an fp2 stream.
  // c0 travels with sop, c1 with eop.
  // 391 bits in all.
  typedef struct packed {
    fe_t  dat;
    logic sop;
    logic eop;
    tag_t ctl;
  } fe_beat_t;

  // operand or result pair.
  // on the result side only c0 and ctl carry data.
  // 770 bits in all.
  typedef struct packed {
    fe_t  c0;
    fe_t  c1;
    tag_t ctl;
  } fe2_pair_t;

endpackage
